// File: common/vchess_pkg.sv
package vchess_pkg;

   localparam int AXI_ADDR_WIDTH = 16;
   localparam int AXI_DATA_WIDTH = 32;

   localparam int SQUARE_WIDTH = 6;  // Row * 8 + column
   localparam int MOVE_WIDTH = 2 * SQUARE_WIDTH;  // From in upper half, to in lower half

   localparam logic [1:0] RESP_OKAY = 2'b00;

   // Word addresses, byte address bits 15:2
   typedef enum logic [13:0] {
      REG_CTRL       = 14'd0,
      REG_MOVE_INDEX = 14'd1,
      REG_SQUARE     = 14'd2,
      REG_OCC_LO     = 14'd8,
      REG_OCC_HI     = 14'd9,
      REG_MOVE_COUNT = 14'd16,
      REG_MOVE       = 14'd17
   } reg_addr_e;

   typedef enum logic [1:0] {
      GEN_IDLE,
      GEN_SCAN,
      GEN_DONE
   } gen_state_e;

   // Knight offsets in scan order, (row, column)
   localparam logic signed [2:0] KNIGHT_DROW [8] = '{
      3'sd2, 3'sd1, -3'sd1, -3'sd2, -3'sd2, -3'sd1, 3'sd1, 3'sd2
   };
   localparam logic signed [2:0] KNIGHT_DCOL [8] = '{
      3'sd1, 3'sd2, 3'sd2, 3'sd1, -3'sd1, -3'sd2, -3'sd2, -3'sd1
   };

endpackage

// File: logic/axi4lite_write.sv
`timescale 1ns/1ps

module axi4lite_write
   import vchess_pkg::*;
(
   input  logic                      clk,
   input  logic                      rst_n,
   input  logic [AXI_ADDR_WIDTH-1:0] awaddr,
   input  logic                      awvalid,
   input  logic [AXI_DATA_WIDTH-1:0] wdata,
   input  logic                      wvalid,
   input  logic                      bready,
   output logic                      awready,
   output logic                      wready,
   output logic                      bvalid,
   output logic [1:0]                bresp,
   output logic                      wr_valid,
   output logic [AXI_ADDR_WIDTH-1:0] wr_addr,
   output logic [AXI_DATA_WIDTH-1:0] wr_data
);

   logic aw_full;
   logic w_full;

   assign awready = !aw_full && !bvalid;
   assign wready  = !w_full && !bvalid;
   assign bresp   = RESP_OKAY;

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         aw_full  <= 1'b0;
         w_full   <= 1'b0;
         wr_valid <= 1'b0;
         bvalid   <= 1'b0;
      end
      else
      begin
         wr_valid <= 1'b0;
         if (aw_full && w_full)
         begin
            aw_full  <= 1'b0;  // Both halves in, issue the write
            w_full   <= 1'b0;
            wr_valid <= 1'b1;
            bvalid   <= 1'b1;
         end
         else
         begin
            if (awvalid && awready)
               aw_full <= 1'b1;
            if (wvalid && wready)
               w_full <= 1'b1;
         end
         if (bvalid && bready)
            bvalid <= 1'b0;
      end
   end

   always_ff @(posedge clk)
   begin
      if (awvalid && awready)
         wr_addr <= awaddr;
      if (wvalid && wready)
         wr_data <= wdata;
   end

endmodule

// File: control/control.sv
`timescale 1ns/1ps

module control
   import vchess_pkg::*;
#(
   parameter int MAX_POSITIONS = 8,
   parameter int COUNT_WIDTH = $clog2(MAX_POSITIONS + 1)
)
(
   input  logic                      clk,
   input  logic                      rst_n,
   input  logic [AXI_ADDR_WIDTH-1:0] awaddr,
   input  logic                      awvalid,
   output logic                      awready,
   input  logic [AXI_DATA_WIDTH-1:0] wdata,
   input  logic                      wvalid,
   output logic                      wready,
   output logic [1:0]                bresp,
   output logic                      bvalid,
   input  logic                      bready,
   input  logic [AXI_ADDR_WIDTH-1:0] araddr,
   input  logic                      arvalid,
   output logic                      arready,
   output logic [AXI_DATA_WIDTH-1:0] rdata,
   output logic [1:0]                rresp,
   output logic                      rvalid,
   input  logic                      rready,
   input  logic                      gen_idle,
   input  logic                      moves_ready,
   input  logic [COUNT_WIDTH-1:0]    move_count,
   input  logic [MOVE_WIDTH-1:0]     move_out,
   input  logic                      move_ready,
   output logic                      start,
   output logic [SQUARE_WIDTH-1:0]   square,
   output logic [63:0]               occupancy,
   output logic [COUNT_WIDTH-1:0]    move_index
);

   logic                      wr_valid;
   logic [AXI_ADDR_WIDTH-1:0] wr_addr;
   logic [AXI_DATA_WIDTH-1:0] wr_data;
   reg_addr_e                 wr_reg;
   reg_addr_e                 rd_reg;

   assign wr_reg  = reg_addr_e'(wr_addr[15:2]);
   assign rd_reg  = reg_addr_e'(araddr[15:2]);
   assign arready = 1'b1;
   assign rresp   = RESP_OKAY;

   axi4lite_write axi4lite_write_inst (
      .clk      (clk),
      .rst_n    (rst_n),
      .awaddr   (awaddr),
      .awvalid  (awvalid),
      .wdata    (wdata),
      .wvalid   (wvalid),
      .bready   (bready),
      .awready  (awready),
      .wready   (wready),
      .bvalid   (bvalid),
      .bresp    (bresp),
      .wr_valid (wr_valid),
      .wr_addr  (wr_addr),
      .wr_data  (wr_data)
   );

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         start      <= 1'b0;
         square     <= '0;
         occupancy  <= '0;
         move_index <= '0;
      end
      else
      begin
         start <= 1'b0;  // Pulse only
         if (wr_valid)
         begin
            case (wr_reg)
               REG_CTRL:       start <= wr_data[0];
               REG_MOVE_INDEX: move_index <= wr_data[COUNT_WIDTH-1:0];
               REG_SQUARE:     square <= wr_data[SQUARE_WIDTH-1:0];
               REG_OCC_LO:     occupancy[31:0] <= wr_data;
               REG_OCC_HI:     occupancy[63:32] <= wr_data;
               default:        ;  // Read-only or unmapped
            endcase
         end
      end
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         rvalid <= 1'b0;
      else if (rvalid && rready)
         rvalid <= 1'b0;
      else if (arvalid)
         rvalid <= 1'b1;
   end

   // Data captured only when no response is pending
   always_ff @(posedge clk)
   begin
      if (arvalid && !rvalid)
      begin
         case (rd_reg)
            REG_CTRL:       rdata <= {30'd0, gen_idle, moves_ready};
            REG_MOVE_INDEX: rdata <= AXI_DATA_WIDTH'(move_index);
            REG_SQUARE:     rdata <= AXI_DATA_WIDTH'(square);
            REG_OCC_LO:     rdata <= occupancy[31:0];
            REG_OCC_HI:     rdata <= occupancy[63:32];
            REG_MOVE_COUNT: rdata <= AXI_DATA_WIDTH'(move_count);
            REG_MOVE:       rdata <= {move_ready, 19'd0, move_out};
            default:        rdata <= '0;
         endcase
      end
   end

endmodule

// File: logic/knight_move_gen.sv
`timescale 1ns/1ps

module knight_move_gen
   import vchess_pkg::*;
#(
   parameter int MAX_POSITIONS = 8,
   parameter int COUNT_WIDTH = $clog2(MAX_POSITIONS + 1)
)
(
   input  logic                    clk,
   input  logic                    rst_n,
   input  logic                    start,
   input  logic [SQUARE_WIDTH-1:0] square,
   input  logic [63:0]             occupancy,
   output logic                    list_wr_en,
   output logic [MOVE_WIDTH-1:0]   list_wr_move,
   output logic                    gen_idle,
   output logic                    moves_ready
);

   gen_state_e              state;
   logic [2:0]              step;
   logic [COUNT_WIDTH-1:0]  kept;
   logic signed [4:0]       tgt_row;
   logic signed [4:0]       tgt_col;
   logic [SQUARE_WIDTH-1:0] tgt_square;
   logic                    on_board;
   logic                    keep;

   assign tgt_row    = $signed({2'b00, square[5:3]}) + KNIGHT_DROW[step];
   assign tgt_col    = $signed({2'b00, square[2:0]}) + KNIGHT_DCOL[step];
   assign on_board   = (tgt_row[4:3] == 2'b00) && (tgt_col[4:3] == 2'b00);  // 0 to 7
   assign tgt_square = {tgt_row[2:0], tgt_col[2:0]};
   assign keep       = on_board && !occupancy[tgt_square]
                       && (kept < COUNT_WIDTH'(MAX_POSITIONS));

   assign list_wr_en   = (state == GEN_SCAN) && keep;
   assign list_wr_move = {square, tgt_square};
   assign gen_idle     = (state != GEN_SCAN);
   assign moves_ready  = (state == GEN_DONE);

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         state <= GEN_IDLE;
         step  <= '0;
         kept  <= '0;
      end
      else
      begin
         case (state)
            GEN_SCAN:
            begin
               if (keep)
                  kept <= kept + 1'b1;
               if (step == 3'd7)
                  state <= GEN_DONE;
               step <= step + 1'b1;  // Wraps back to 0
            end
            default:
            begin
               if (start)
               begin
                  state <= GEN_SCAN;
                  step  <= '0;
                  kept  <= '0;
               end
            end
         endcase
      end
   end

endmodule

// File: logic/move_list.sv
`timescale 1ns/1ps

module move_list
   import vchess_pkg::*;
#(
   parameter int MAX_POSITIONS = 8,
   parameter int COUNT_WIDTH = $clog2(MAX_POSITIONS + 1)
)
(
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   start,
   input  logic                   list_wr_en,
   input  logic [MOVE_WIDTH-1:0]  list_wr_move,
   input  logic                   moves_ready,
   input  logic [COUNT_WIDTH-1:0] move_index,
   output logic [COUNT_WIDTH-1:0] move_count,
   output logic [MOVE_WIDTH-1:0]  move_out,
   output logic                   move_ready
);

   localparam int IDX_WIDTH = $clog2(MAX_POSITIONS);

   logic [MOVE_WIDTH-1:0] mem [MAX_POSITIONS];
   logic                  full;
   logic                  index_ok;

   assign full     = (move_count == COUNT_WIDTH'(MAX_POSITIONS));
   assign index_ok = moves_ready && (move_index < move_count);

   // Write pointer doubles as the count
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         move_count <= '0;
      else if (start)
         move_count <= '0;
      else if (list_wr_en && !full)
         move_count <= move_count + 1'b1;
   end

   always_ff @(posedge clk)
   begin
      if (list_wr_en && !full)
         mem[move_count[IDX_WIDTH-1:0]] <= list_wr_move;
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         move_out   <= '0;
         move_ready <= 1'b0;
      end
      else
      begin
         move_ready <= index_ok;
         move_out   <= index_ok ? mem[move_index[IDX_WIDTH-1:0]] : '0;  // Zero when out of range
      end
   end

endmodule

// File: logic/vchess_top.sv
`timescale 1ns/1ps

module vchess_top
   import vchess_pkg::*;
#(
   parameter int MAX_POSITIONS = 8
)
(
   input  logic                      clk,
   input  logic                      rst_n,
   input  logic [AXI_ADDR_WIDTH-1:0] awaddr,
   input  logic                      awvalid,
   output logic                      awready,
   input  logic [AXI_DATA_WIDTH-1:0] wdata,
   input  logic                      wvalid,
   output logic                      wready,
   output logic [1:0]                bresp,
   output logic                      bvalid,
   input  logic                      bready,
   input  logic [AXI_ADDR_WIDTH-1:0] araddr,
   input  logic                      arvalid,
   output logic                      arready,
   output logic [AXI_DATA_WIDTH-1:0] rdata,
   output logic [1:0]                rresp,
   output logic                      rvalid,
   input  logic                      rready
);

   localparam int COUNT_WIDTH = $clog2(MAX_POSITIONS + 1);

   logic                    start;
   logic [SQUARE_WIDTH-1:0] square;
   logic [63:0]             occupancy;
   logic [COUNT_WIDTH-1:0]  move_index;
   logic [COUNT_WIDTH-1:0]  move_count;
   logic [MOVE_WIDTH-1:0]   move_out;
   logic                    move_ready;
   logic                    list_wr_en;
   logic [MOVE_WIDTH-1:0]   list_wr_move;
   logic                    gen_idle;
   logic                    moves_ready;

   control #(
      .MAX_POSITIONS (MAX_POSITIONS)
   ) control_inst (
      .clk         (clk),
      .rst_n       (rst_n),
      .awaddr      (awaddr),
      .awvalid     (awvalid),
      .awready     (awready),
      .wdata       (wdata),
      .wvalid      (wvalid),
      .wready      (wready),
      .bresp       (bresp),
      .bvalid      (bvalid),
      .bready      (bready),
      .araddr      (araddr),
      .arvalid     (arvalid),
      .arready     (arready),
      .rdata       (rdata),
      .rresp       (rresp),
      .rvalid      (rvalid),
      .rready      (rready),
      .gen_idle    (gen_idle),
      .moves_ready (moves_ready),
      .move_count  (move_count),
      .move_out    (move_out),
      .move_ready  (move_ready),
      .start       (start),
      .square      (square),
      .occupancy   (occupancy),
      .move_index  (move_index)
   );

   knight_move_gen #(
      .MAX_POSITIONS (MAX_POSITIONS)
   ) knight_move_gen_inst (
      .clk          (clk),
      .rst_n        (rst_n),
      .start        (start),
      .square       (square),
      .occupancy    (occupancy),
      .list_wr_en   (list_wr_en),
      .list_wr_move (list_wr_move),
      .gen_idle     (gen_idle),
      .moves_ready  (moves_ready)
   );

   move_list #(
      .MAX_POSITIONS (MAX_POSITIONS)
   ) move_list_inst (
      .clk          (clk),
      .rst_n        (rst_n),
      .start        (start),
      .list_wr_en   (list_wr_en),
      .list_wr_move (list_wr_move),
      .moves_ready  (moves_ready),
      .move_index   (move_index),
      .move_count   (move_count),
      .move_out     (move_out),
      .move_ready   (move_ready)
   );

endmodule

// File: bench/vchess_asserts.sv
`timescale 1ns/1ps

module vchess_asserts
   import vchess_pkg::*;
(
   input logic                      clk,
   input logic                      rst_n,
   input logic                      awready,
   input logic                      wready,
   input logic                      bvalid,
   input logic                      bready,
   input logic                      rvalid,
   input logic                      rready,
   input logic [AXI_DATA_WIDTH-1:0] rdata
);

   bvalid_held: assert property (@(posedge clk) disable iff (!rst_n)
      bvalid && !bready |=> bvalid)
      else $error("bvalid dropped before bready");

   read_stable: assert property (@(posedge clk) disable iff (!rst_n)
      rvalid && !rready |=> rvalid && $stable(rdata))
      else $error("rvalid or rdata changed while rready was low");

   no_ready_in_resp: assert property (@(posedge clk) disable iff (!rst_n)
      bvalid |-> !awready && !wready)
      else $error("awready or wready high while bvalid pending");

   // First sampled cycle out of reset
   quiet_after_reset: assert property (@(posedge clk)
      $rose(rst_n) |-> !rvalid && !bvalid)
      else $error("rvalid or bvalid high right after reset");

endmodule

// File: bench/tb_vchess.sv
`timescale 1ns/1ps

module tb_vchess
   import vchess_pkg::*;
;

   localparam int TIMEOUT = 100;
   localparam logic [15:0] ADDR_CTRL       = 16'h0000;
   localparam logic [15:0] ADDR_MOVE_INDEX = 16'h0004;
   localparam logic [15:0] ADDR_SQUARE     = 16'h0008;
   localparam logic [15:0] ADDR_UNMAPPED   = 16'h0014;
   localparam logic [15:0] ADDR_OCC_LO     = 16'h0020;
   localparam logic [15:0] ADDR_OCC_HI     = 16'h0024;
   localparam logic [15:0] ADDR_MOVE_COUNT = 16'h0040;
   localparam logic [15:0] ADDR_MOVE       = 16'h0044;

   logic        clk;
   logic        rst_n;
   logic [15:0] awaddr;
   logic        awvalid;
   logic        awready;
   logic [31:0] wdata;
   logic        wvalid;
   logic        wready;
   logic [1:0]  bresp;
   logic        bvalid;
   logic        bready;
   logic [15:0] araddr;
   logic        arvalid;
   logic        arready;
   logic [31:0] rdata;
   logic [1:0]  rresp;
   logic        rvalid;
   logic        rready;

   integer      seed = 32'h11587190;
   int          fail_count = 0;
   int          exp_count;
   logic [5:0]  exp_dest [8];
   int          drow [8] = '{2, 1, -1, -2, -2, -1, 1, 2};
   int          dcol [8] = '{1, 2, 2, 1, -1, -2, -2, -1};

   vchess_top #(
      .MAX_POSITIONS (8)
   ) vchess_top_inst (
      .clk     (clk),
      .rst_n   (rst_n),
      .awaddr  (awaddr),
      .awvalid (awvalid),
      .awready (awready),
      .wdata   (wdata),
      .wvalid  (wvalid),
      .wready  (wready),
      .bresp   (bresp),
      .bvalid  (bvalid),
      .bready  (bready),
      .araddr  (araddr),
      .arvalid (arvalid),
      .arready (arready),
      .rdata   (rdata),
      .rresp   (rresp),
      .rvalid  (rvalid),
      .rready  (rready)
   );

   bind vchess_top vchess_asserts vchess_asserts_inst (
      .clk     (clk),
      .rst_n   (rst_n),
      .awready (awready),
      .wready  (wready),
      .bvalid  (bvalid),
      .bready  (bready),
      .rvalid  (rvalid),
      .rready  (rready),
      .rdata   (rdata)
   );

   initial
   begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   task report_timeout(input string what);
      $display("Timeout while waiting for %s at %0t", what, $time);
      $display("Simulation failed");
      $fatal(1, "Handshake timeout");
   endtask

   task check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
      assert (got === exp)
      else
      begin
         fail_count++;
         $display("MISMATCH at %0t: %s read 0x%08h, expected 0x%08h", $time, name, got, exp);
         $display("Simulation failed");
         $fatal(1, "Value check failed");
      end
   endtask

   task axi_write(input logic [15:0] addr, input logic [31:0] data);
      int   cycles;
      int   delay;
      logic data_first;
      logic aw_take;
      logic w_take;
      logic aw_sent;
      logic w_sent;
      data_first = ($random(seed) & 1) != 0;
      aw_sent = 1'b0;
      w_sent = 1'b0;
      cycles = 0;
      @(negedge clk);
      wdata = data;
      wvalid = 1'b1;
      if (!data_first)
      begin
         awaddr = addr;
         awvalid = 1'b1;
      end
      while (!(aw_sent && w_sent))
      begin
         aw_take = awvalid && awready;
         w_take = wvalid && wready;
         @(negedge clk);
         if (aw_take)
         begin
            awvalid = 1'b0;
            aw_sent = 1'b1;
         end
         if (w_take)
         begin
            wvalid = 1'b0;
            w_sent = 1'b1;
         end
         if (w_sent && !aw_sent && !awvalid)
         begin
            awaddr = addr;  // Address half after the data half
            awvalid = 1'b1;
         end
         cycles++;
         if (cycles > TIMEOUT)
            report_timeout("awready and wready");
      end
      cycles = 0;
      while (!bvalid)
      begin
         @(negedge clk);
         cycles++;
         if (cycles > TIMEOUT)
            report_timeout("bvalid");
      end
      check_value("BRESP", 32'(bresp), 32'd0);
      delay = $random(seed) & 3;
      repeat (delay) @(negedge clk);
      bready = 1'b1;
      @(negedge clk);
      bready = 0;
      repeat (2) @(negedge clk);  // Start pulse and indexed read settle
   endtask

   task axi_read(input logic [15:0] addr, output logic [31:0] data);
      int cycles;
      int delay;
      cycles = 0;
      @(negedge clk);
      araddr = addr;
      arvalid = 1'b1;
      while (!arready)
      begin
         @(negedge clk);
         cycles++;
         if (cycles > TIMEOUT)
            report_timeout("arready");
      end
      @(negedge clk);
      arvalid = 1'b0;
      cycles = 0;
      while (!rvalid)
      begin
         @(negedge clk);
         cycles++;
         if (cycles > TIMEOUT)
            report_timeout("rvalid");
      end
      delay = $random(seed) & 3;
      repeat (delay) @(negedge clk);
      data = rdata;
      check_value("RRESP", 32'(rresp), 32'd0);
      rready = 1'b1;
      @(negedge clk);
      rready = 1'b0;
   endtask

   // Knight destinations in offset order
   task compute_expected(input logic [5:0] sq, input logic [63:0] occ);
      int r;
      int c;
      exp_count = 0;
      for (int i = 0; i < 8; i++)
      begin
         r = int'(sq[5:3]) + drow[i];
         c = int'(sq[2:0]) + dcol[i];
         if (r >= 0 && r < 8 && c >= 0 && c < 8 && !occ[r * 8 + c])
         begin
            exp_dest[exp_count] = 6'(r * 8 + c);
            exp_count++;
         end
      end
   endtask

   task wait_moves_ready();
      logic [31:0] data;
      int          polls;
      polls = 0;
      data = '0;
      while (!data[0])
      begin
         axi_read(ADDR_CTRL, data);
         polls++;
         if (polls > TIMEOUT && !data[0])
            report_timeout("moves_ready");
      end
      check_value("REG_CTRL", data, 32'd3);
   endtask

   task run_position(input logic [5:0] sq, input logic [63:0] occ);
      logic [31:0] data;
      compute_expected(sq, occ);
      axi_write(ADDR_SQUARE, 32'(sq));
      axi_write(ADDR_OCC_LO, occ[31:0]);
      axi_write(ADDR_OCC_HI, occ[63:32]);
      axi_write(ADDR_CTRL, 32'd1);
      wait_moves_ready();
      axi_read(ADDR_MOVE_COUNT, data);
      check_value("REG_MOVE_COUNT", data, 32'(exp_count));
      for (int i = 0; i < exp_count; i++)
      begin
         axi_write(ADDR_MOVE_INDEX, 32'(i));
         axi_read(ADDR_MOVE, data);
         check_value("REG_MOVE", data, {1'b1, 19'd0, sq, exp_dest[i]});
      end
      axi_write(ADDR_MOVE_INDEX, 32'(exp_count));
      axi_read(ADDR_MOVE, data);
      check_value("REG_MOVE out of range", data, 32'd0);
   endtask

   initial
   begin
      logic [31:0] data;
      logic [5:0]  sq;
      logic [63:0] occ;
      rst_n = 1'b0;
      awaddr = '0;
      awvalid = 1'b0;
      wdata = '0;
      wvalid = 1'b0;
      bready = 1'b0;
      araddr = '0;
      arvalid = 1'b0;
      rready = 1'b0;
      repeat (16) @(negedge clk);
      rst_n = 1'b1;

      axi_read(ADDR_CTRL, data);
      check_value("REG_CTRL", data, 32'd2);  // Idle, no moves
      axi_write(ADDR_SQUARE, 32'd45);
      axi_read(ADDR_SQUARE, data);
      check_value("REG_SQUARE", data, 32'd45);
      axi_write(ADDR_OCC_LO, 32'ha5c3_0f96);
      axi_read(ADDR_OCC_LO, data);
      check_value("REG_OCC_LO", data, 32'ha5c3_0f96);
      axi_write(ADDR_OCC_HI, 32'h5a3c_f069);
      axi_read(ADDR_OCC_HI, data);
      check_value("REG_OCC_HI", data, 32'h5a3c_f069);
      axi_write(ADDR_MOVE_INDEX, 32'd6);
      axi_read(ADDR_MOVE_INDEX, data);
      check_value("REG_MOVE_INDEX", data, 32'd6);
      axi_read(ADDR_UNMAPPED, data);
      check_value("unmapped address", data, 32'd0);

      run_position(6'd0, 64'd0);  // Corners
      run_position(6'd63, 64'd0);
      run_position(6'd4, 64'h0000_0000_0000_2000);  // Edges
      run_position(6'd32, 64'd0);
      run_position(6'd27, 64'h0000_0010_0020_0000);  // Centre
      run_position(6'd27, 64'hffff_ffff_ffff_ffff);
      for (int n = 0; n < 8; n++)
      begin
         sq = 6'($random(seed));
         occ = {32'($random(seed)), 32'($random(seed))};
         run_position(sq, occ);
      end

      if (fail_count == 0)
      begin
         $display("Simulation completed successfully");
      end
      else
      begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

// File: sim.f
common/vchess_pkg.sv
logic/axi4lite_write.sv
control/control.sv
logic/knight_move_gen.sv
logic/move_list.sv
logic/vchess_top.sv
bench/vchess_asserts.sv
bench/tb_vchess.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --assert --timing -f sim.f --top-module tb_vchess -Mdir obj_dir
./obj_dir/Vtb_vchess > sim.log 2>&1 || true
cat sim.log
if grep -q "Simulation failed" sim.log; then
   exit 1
fi
if ! grep -q "Simulation completed successfully" sim.log; then
   exit 1
fi
